/* verilog/l1d_access_pkg.sv */
package l1d_access_pkg;

  // Address split: tag | index | offset
  localparam int PADDR_W    = 12;
  localparam int LINE_W     = 128;
  localparam int LINE_B_W   = LINE_W / 8;
  localparam int XLEN_W     = 32;
  localparam int OFFSET_W   = 4;
  localparam int INDEX_W    = 3;
  localparam int TAG_W      = PADDR_W - INDEX_W - OFFSET_W;
  localparam int WAYS       = 2;
  localparam int SETS       = 1 << INDEX_W;
  localparam int WORD_SEL_W = 2;

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [LINE_W-1:0]  line_t;
  typedef logic [WAYS-1:0]    way_oh_t;

  typedef enum logic [1:0] {
    STATUS_NONE         = 2'd0,
    STATUS_HIT          = 2'd1,
    STATUS_MISS         = 2'd2,
    STATUS_L1D_CONFLICT = 2'd3
  } l1d_status_t;

  typedef enum logic {
    SNOOP_READ    = 1'b0,
    SNOOP_INVALID = 1'b1
  } snoop_cmd_t;

  // Stage-1 flags to status, conflict first
  function automatic l1d_status_t encode_status(input logic conflict, input logic hit,
                                                input logic miss);
    if (conflict) return STATUS_L1D_CONFLICT;
    if (hit) return STATUS_HIT;
    if (miss) return STATUS_MISS;
    return STATUS_NONE;
  endfunction

endpackage

/* verilog/l1d_rd_if.sv */
`timescale 1ns/10ps

interface l1d_rd_if
  import l1d_access_pkg::*;
();

  // Stage 0 request
  logic    s0_valid;
  paddr_t  s0_paddr;

  // Stage 1 result, one cycle after the request
  logic    s1_conflict;
  logic    s1_hit;
  logic    s1_miss;
  way_oh_t s1_hit_way;
  line_t   s1_data;

  modport master (
    output s0_valid, s0_paddr,
    input  s1_conflict, s1_hit, s1_miss, s1_hit_way, s1_data
  );

  modport slave (
    input  s0_valid, s0_paddr,
    output s1_conflict, s1_hit, s1_miss, s1_hit_way, s1_data
  );

endinterface

/* verilog/l1d_wr_if.sv */
`timescale 1ns/10ps

interface l1d_wr_if
  import l1d_access_pkg::*;
();

  logic    s0_valid;
  way_oh_t s0_way;
  paddr_t  s0_paddr;
  line_t   s0_data;
  // Cleared for an invalidate
  logic    s0_line_valid;

  modport master (output s0_valid, s0_way, s0_paddr, s0_data, s0_line_valid);

  modport slave (input s0_valid, s0_way, s0_paddr, s0_data, s0_line_valid);

endinterface

/* verilog/l1d_tag_data_array.sv */
`timescale 1ns/10ps

module l1d_tag_data_array
  import l1d_access_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,
  input  logic    i_rd_valid,
  input  paddr_t  i_rd_paddr,
  input  logic    i_wr_valid,
  input  way_oh_t i_wr_way,
  input  paddr_t  i_wr_paddr,
  input  line_t   i_wr_data,
  input  logic    i_wr_line_valid,
  output logic    o_rd_hit,
  output way_oh_t o_rd_hit_way,
  output line_t   o_rd_line
);

  logic [WAYS-1:0][SETS-1:0] r_valid;
  logic [TAG_W-1:0]          r_tag  [WAYS][SETS];
  line_t                     r_data [WAYS][SETS];

  logic [INDEX_W-1:0] w_rd_index;
  logic [INDEX_W-1:0] w_wr_index;
  logic [TAG_W-1:0]   w_rd_tag;
  way_oh_t            w_hit_vec;
  line_t              w_hit_line;
  way_oh_t            r_hit_way;
  line_t              r_line;

  assign w_rd_index = i_rd_paddr[OFFSET_W +: INDEX_W];
  assign w_rd_tag   = i_rd_paddr[PADDR_W-1 -: TAG_W];
  assign w_wr_index = i_wr_paddr[OFFSET_W +: INDEX_W];

  // Tag compare in both ways, then pick the hit line
  always_comb begin
    w_hit_line = '0;
    for (int w = 0; w < WAYS; w++) begin
      w_hit_vec[w] = r_valid[w][w_rd_index] & (r_tag[w][w_rd_index] == w_rd_tag);
      if (w_hit_vec[w]) begin
        w_hit_line = w_hit_line | r_data[w][w_rd_index];
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid   <= '0;
      r_hit_way <= '0;
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        if (i_wr_valid && i_wr_way[w]) begin
          r_valid[w][w_wr_index] <= i_wr_line_valid;
        end
      end
      r_hit_way <= i_rd_valid ? w_hit_vec : '0;
    end
  end

  always_ff @(posedge i_clk) begin
    for (int w = 0; w < WAYS; w++) begin
      if (i_wr_valid && i_wr_way[w]) begin
        r_tag[w][w_wr_index]  <= i_wr_paddr[PADDR_W-1 -: TAG_W];
        r_data[w][w_wr_index] <= i_wr_data;
      end
    end
    r_line <= w_hit_line;
  end

  assign o_rd_hit     = |r_hit_way;
  assign o_rd_hit_way = r_hit_way;
  assign o_rd_line    = r_line;

endmodule

/* verilog/l1d_dcache.sv */
`timescale 1ns/10ps

module l1d_dcache
  import l1d_access_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,
  l1d_rd_if.slave  snoop_rd,
  l1d_rd_if.slave  ptw_rd,
  l1d_wr_if.slave  snoop_wr,
  input  logic     i_fill_valid,
  input  paddr_t   i_fill_paddr,
  input  way_oh_t  i_fill_way,
  input  line_t    i_fill_data,
  output logic     o_fill_ready
);

  logic    w_snoop_req;
  logic    w_fill_grant;
  logic    w_ptw_grant;
  logic    r_snoop_rd_grant;
  logic    r_ptw_rd_grant;
  logic    r_ptw_conflict;
  logic    w_rd_hit;
  way_oh_t w_rd_hit_way;
  line_t   w_rd_line;

  // -----------------------------------------------
  // Grant: snoop, then fill, then page walk
  // -----------------------------------------------
  assign w_snoop_req  = snoop_rd.s0_valid | snoop_wr.s0_valid;
  assign o_fill_ready = ~w_snoop_req;
  assign w_fill_grant = i_fill_valid & ~w_snoop_req;
  assign w_ptw_grant  = ptw_rd.s0_valid & ~w_snoop_req & ~i_fill_valid;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_snoop_rd_grant <= 1'b0;
      r_ptw_rd_grant   <= 1'b0;
      r_ptw_conflict   <= 1'b0;
    end else begin
      r_snoop_rd_grant <= snoop_rd.s0_valid;
      r_ptw_rd_grant   <= w_ptw_grant;
      r_ptw_conflict   <= ptw_rd.s0_valid & ~w_ptw_grant;
    end
  end

  l1d_tag_data_array u_array (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_rd_valid     (snoop_rd.s0_valid | w_ptw_grant),
    .i_rd_paddr     (snoop_rd.s0_valid ? snoop_rd.s0_paddr : ptw_rd.s0_paddr),
    .i_wr_valid     (snoop_wr.s0_valid | w_fill_grant),
    .i_wr_way       (snoop_wr.s0_valid ? snoop_wr.s0_way : i_fill_way),
    .i_wr_paddr     (snoop_wr.s0_valid ? snoop_wr.s0_paddr : i_fill_paddr),
    .i_wr_data      (snoop_wr.s0_valid ? snoop_wr.s0_data : i_fill_data),
    .i_wr_line_valid(snoop_wr.s0_valid ? snoop_wr.s0_line_valid : 1'b1),
    .o_rd_hit       (w_rd_hit),
    .o_rd_hit_way   (w_rd_hit_way),
    .o_rd_line      (w_rd_line)
  );

  // -----------------------------------------------
  // Stage 1 result to the granted reader
  // -----------------------------------------------
  // Snoop never loses arbitration
  assign snoop_rd.s1_conflict = 1'b0;
  assign snoop_rd.s1_hit      = r_snoop_rd_grant & w_rd_hit;
  assign snoop_rd.s1_miss     = r_snoop_rd_grant & ~w_rd_hit;
  assign snoop_rd.s1_hit_way  = r_snoop_rd_grant ? w_rd_hit_way : '0;
  assign snoop_rd.s1_data     = w_rd_line;

  assign ptw_rd.s1_conflict = r_ptw_conflict;
  assign ptw_rd.s1_hit      = r_ptw_rd_grant & w_rd_hit;
  assign ptw_rd.s1_miss     = r_ptw_rd_grant & ~w_rd_hit;
  assign ptw_rd.s1_hit_way  = r_ptw_rd_grant ? w_rd_hit_way : '0;
  assign ptw_rd.s1_data     = w_rd_line;

endmodule

/* verilog/l1d_ptw_access.sv */
`timescale 1ns/10ps

module l1d_ptw_access
  import l1d_access_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_req_valid,
  input  paddr_t           i_paddr,
  output logic             o_resp_valid,
  output l1d_status_t      o_status,
  output logic [XLEN_W-1:0] o_data,
  l1d_rd_if.master         rd
);

  logic                  r_resp_valid;
  logic [WORD_SEL_W-1:0] r_word_sel;

  assign rd.s0_valid = i_req_valid;
  assign rd.s0_paddr = i_paddr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_valid <= 1'b0;
    end else begin
      r_resp_valid <= i_req_valid;
    end
  end

  // Word position in the line, bits just above the byte-in-word offset
  always_ff @(posedge i_clk) begin
    r_word_sel <= i_paddr[OFFSET_W-WORD_SEL_W +: WORD_SEL_W];
  end

  assign o_resp_valid = r_resp_valid;
  assign o_status     = encode_status(rd.s1_conflict, rd.s1_hit, rd.s1_miss);
  assign o_data       = rd.s1_data[r_word_sel * XLEN_W +: XLEN_W];

endmodule

/* verilog/l1d_snoop_port.sv */
`timescale 1ns/10ps

module l1d_snoop_port
  import l1d_access_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_req_valid,
  input  snoop_cmd_t          i_cmd,
  input  paddr_t              i_paddr,
  input  way_oh_t             i_ways,
  output logic                o_resp_valid,
  output l1d_status_t         o_status,
  output way_oh_t             o_ways,
  output logic [LINE_B_W-1:0] o_be,
  output line_t               o_data,
  l1d_rd_if.master            rd,
  l1d_wr_if.master            wr
);

  logic r_resp_valid;

  // -----------------------------------------------
  // Request split by command
  // -----------------------------------------------
  assign rd.s0_valid = i_req_valid & (i_cmd == SNOOP_READ);
  assign rd.s0_paddr = i_paddr;

  // Invalidate writes the named ways with the valid bit cleared
  assign wr.s0_valid      = i_req_valid & (i_cmd == SNOOP_INVALID);
  assign wr.s0_way        = i_ways;
  assign wr.s0_paddr      = i_paddr;
  assign wr.s0_data       = '0;
  assign wr.s0_line_valid = 1'b0;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_valid <= 1'b0;
    end else begin
      r_resp_valid <= i_req_valid;
    end
  end

  // Response, NONE for an invalidate since no flag is set
  assign o_resp_valid = r_resp_valid;
  assign o_status     = encode_status(rd.s1_conflict, rd.s1_hit, rd.s1_miss);
  assign o_ways       = rd.s1_hit_way;
  assign o_be         = rd.s1_hit ? {LINE_B_W{1'b1}} : {LINE_B_W{1'b0}};
  assign o_data       = rd.s1_data;

endmodule

/* verilog/l1d_access_top.sv */
`timescale 1ns/10ps

module l1d_access_top
  import l1d_access_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,

  // Page-table walk access
  input  logic                i_ptw_req_valid,
  input  paddr_t              i_ptw_paddr,
  output logic                o_ptw_resp_valid,
  output l1d_status_t         o_ptw_status,
  output logic [XLEN_W-1:0]   o_ptw_data,

  // Coherence snoop
  input  logic                i_snoop_req_valid,
  input  snoop_cmd_t          i_snoop_cmd,
  input  paddr_t              i_snoop_paddr,
  input  way_oh_t             i_snoop_ways,
  output logic                o_snoop_resp_valid,
  output l1d_status_t         o_snoop_status,
  output way_oh_t             o_snoop_ways,
  output logic [LINE_B_W-1:0] o_snoop_be,
  output line_t               o_snoop_data,

  // Line fill
  input  logic                i_fill_valid,
  input  paddr_t              i_fill_paddr,
  input  way_oh_t             i_fill_way,
  input  line_t               i_fill_data,
  output logic                o_fill_ready
);

  l1d_rd_if w_ptw_rd_if ();
  l1d_rd_if w_snoop_rd_if ();
  l1d_wr_if w_snoop_wr_if ();

  // -----------------------------------------------
  // Side doors
  // -----------------------------------------------
  l1d_ptw_access u_ptw_access (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_req_valid (i_ptw_req_valid),
    .i_paddr     (i_ptw_paddr),
    .o_resp_valid(o_ptw_resp_valid),
    .o_status    (o_ptw_status),
    .o_data      (o_ptw_data),
    .rd          (w_ptw_rd_if)
  );

  l1d_snoop_port u_snoop_port (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_req_valid (i_snoop_req_valid),
    .i_cmd       (i_snoop_cmd),
    .i_paddr     (i_snoop_paddr),
    .i_ways      (i_snoop_ways),
    .o_resp_valid(o_snoop_resp_valid),
    .o_status    (o_snoop_status),
    .o_ways      (o_snoop_ways),
    .o_be        (o_snoop_be),
    .o_data      (o_snoop_data),
    .rd          (w_snoop_rd_if),
    .wr          (w_snoop_wr_if)
  );

  // -----------------------------------------------
  // Data cache
  // -----------------------------------------------
  l1d_dcache u_dcache (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .snoop_rd    (w_snoop_rd_if),
    .ptw_rd      (w_ptw_rd_if),
    .snoop_wr    (w_snoop_wr_if),
    .i_fill_valid(i_fill_valid),
    .i_fill_paddr(i_fill_paddr),
    .i_fill_way  (i_fill_way),
    .i_fill_data (i_fill_data),
    .o_fill_ready(o_fill_ready)
  );

endmodule

/* tb/l1d_access_tb_tasks.svh */
`ifndef L1D_ACCESS_TB_TASKS_SVH
`define L1D_ACCESS_TB_TASKS_SVH

// Compare one value, count and report a mismatch
task automatic check_value(input line_t actual, input line_t expected, input string what);
  if (actual !== expected) begin
    $display("Fail at %0t ns: %s got %0h, expected %0h", $time, what, actual, expected);
    err_count++;
  end
endtask

// Present a line fill and hold it until o_fill_ready is seen
task automatic load_line(input paddr_t addr, input way_oh_t way, input line_t data);
  logic ready;
  @(posedge i_clk);
  i_fill_valid <= 1'b1;
  i_fill_paddr <= addr;
  i_fill_way   <= way;
  i_fill_data  <= data;
  do begin
    @(negedge i_clk);
    ready = o_fill_ready;
    @(posedge i_clk);
  end while (!ready);
  i_fill_valid <= 1'b0;
endtask

// One request cycle, then park at the falling edge of the response cycle
task automatic send_request(input entry_t e);
  @(posedge i_clk);
  i_ptw_req_valid   <= (e.op == OP_PTW) || (e.op == OP_PTW_SNOOP);
  i_ptw_paddr       <= e.addr;
  i_snoop_req_valid <= (e.op != OP_PTW);
  i_snoop_cmd       <= (e.op == OP_SNOOP_INV) ? SNOOP_INVALID : SNOOP_READ;
  i_snoop_paddr     <= e.addr;
  i_snoop_ways      <= e.way;
  if (e.op == OP_FILL_SNOOP) begin
    i_fill_valid <= 1'b1;
    i_fill_paddr <= e.addr;
    i_fill_way   <= e.way;
    i_fill_data  <= e.data;
  end
  @(negedge i_clk);
  fill_ready_seen = o_fill_ready;
  @(posedge i_clk);
  i_ptw_req_valid   <= 1'b0;
  i_snoop_req_valid <= 1'b0;
  @(negedge i_clk);
endtask

`endif

/* tb/l1d_access_tb.sv */
`timescale 1ns/10ps

module l1d_access_tb
  import l1d_access_pkg::*;
();

  typedef enum logic [2:0] {
    OP_FILL, OP_PTW, OP_SNOOP_RD, OP_SNOOP_INV, OP_PTW_SNOOP, OP_FILL_SNOOP
  } op_e;

  // For OP_PTW_SNOOP the expected fields belong to the snoop and the page walk loses
  typedef struct packed {
    op_e                 op;
    paddr_t              addr;
    way_oh_t             way;
    line_t               data;
    l1d_status_t         exp_status;
    line_t               exp_data;
    way_oh_t             exp_ways;
    logic [LINE_B_W-1:0] exp_be;
  } entry_t;

  localparam int N_TESTS        = 19;
  localparam int TIMEOUT_CYCLES = N_TESTS * 4 + 20;

  localparam line_t LINE_A = 128'hdddd0003_cccc0002_bbbb0001_aaaa0000;
  localparam line_t LINE_B = 128'h4444b003_3333b002_2222b001_1111b000;
  localparam line_t LINE_D = 128'h9999d003_8888d002_7777d001_6666d000;

  logic                i_clk;
  logic                i_reset_n;
  logic                i_ptw_req_valid;
  paddr_t              i_ptw_paddr;
  logic                o_ptw_resp_valid;
  l1d_status_t         o_ptw_status;
  logic [XLEN_W-1:0]   o_ptw_data;
  logic                i_snoop_req_valid;
  snoop_cmd_t          i_snoop_cmd;
  paddr_t              i_snoop_paddr;
  way_oh_t             i_snoop_ways;
  logic                o_snoop_resp_valid;
  l1d_status_t         o_snoop_status;
  way_oh_t             o_snoop_ways;
  logic [LINE_B_W-1:0] o_snoop_be;
  line_t               o_snoop_data;
  logic                i_fill_valid;
  paddr_t              i_fill_paddr;
  way_oh_t             i_fill_way;
  line_t               i_fill_data;
  logic                o_fill_ready;

  entry_t tbl [N_TESTS];
  int     err_count;
  int     pass_count;
  int     cycle_count;
  logic   fill_ready_seen;

  l1d_access_top dut_i (.*);

  `include "l1d_access_tb_tasks.svh"

  always #4 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic entry_t make_entry(input op_e op, input paddr_t addr, input way_oh_t way,
                                        input line_t data, input l1d_status_t st,
                                        input line_t exp_data, input way_oh_t exp_ways,
                                        input logic [LINE_B_W-1:0] exp_be);
    return '{op, addr, way, data, st, exp_data, exp_ways, exp_be};
  endfunction

  // --------------------------------------------------
  // Drive one entry and check its responses
  // --------------------------------------------------
  task automatic apply_entry(input entry_t e);
    logic        has_ptw;
    logic        has_snoop;
    l1d_status_t ptw_exp;
    has_ptw   = (e.op == OP_PTW) || (e.op == OP_PTW_SNOOP);
    has_snoop = (e.op != OP_PTW);
    ptw_exp   = (e.op == OP_PTW_SNOOP) ? STATUS_L1D_CONFLICT : e.exp_status;
    send_request(e);
    check_value(LINE_W'(fill_ready_seen), LINE_W'(!has_snoop), "fill ready during request");
    if (has_ptw) begin
      check_value(LINE_W'(o_ptw_resp_valid), LINE_W'(1'b1), "ptw response valid");
      check_value(LINE_W'(o_ptw_status), LINE_W'(ptw_exp), "ptw status");
      if (ptw_exp == STATUS_HIT) begin
        check_value(LINE_W'(o_ptw_data), e.exp_data, "ptw data");
      end
    end else begin
      check_value(LINE_W'(o_ptw_resp_valid), '0, "ptw response valid without request");
    end
    if (has_snoop) begin
      check_value(LINE_W'(o_snoop_resp_valid), LINE_W'(1'b1), "snoop response valid");
      check_value(LINE_W'(o_snoop_status), LINE_W'(e.exp_status), "snoop status");
      check_value(LINE_W'(o_snoop_ways), LINE_W'(e.exp_ways), "snoop ways");
      check_value(LINE_W'(o_snoop_be), LINE_W'(e.exp_be), "snoop byte enables");
      if (e.exp_status == STATUS_HIT) begin
        check_value(o_snoop_data, e.exp_data, "snoop data");
      end
    end else begin
      check_value(LINE_W'(o_snoop_resp_valid), '0, "snoop response valid without request");
    end
    // Held fill goes through once the snoop is gone
    if (e.op == OP_FILL_SNOOP) begin
      check_value(LINE_W'(o_fill_ready), LINE_W'(1'b1), "fill ready after snoop");
      @(posedge i_clk);
      i_fill_valid <= 1'b0;
    end
  endtask

  initial begin
    int errs_before;
    i_clk             = 1'b0;
    i_reset_n         = 1'b0;
    i_ptw_req_valid   = 1'b0;
    i_ptw_paddr       = '0;
    i_snoop_req_valid = 1'b0;
    i_snoop_cmd       = SNOOP_READ;
    i_snoop_paddr     = '0;
    i_snoop_ways      = '0;
    i_fill_valid      = 1'b0;
    i_fill_paddr      = '0;
    i_fill_way        = '0;
    i_fill_data       = '0;
    err_count         = 0;
    pass_count        = 0;
    cycle_count       = 0;
    fill_ready_seen   = 1'b0;

    // A and B share set 2, C is never filled, D goes in under a snoop
    tbl[0]  = make_entry(OP_PTW, 12'h0A4, 2'b00, '0, STATUS_MISS, '0, 2'b00, 16'h0);
    tbl[1]  = make_entry(OP_FILL, 12'h0A0, 2'b01, LINE_A, STATUS_NONE, '0, 2'b00, 16'h0);
    tbl[2]  = make_entry(OP_PTW, 12'h0A0, 2'b00, '0, STATUS_HIT, 128'haaaa0000, 2'b00, 16'h0);
    tbl[3]  = make_entry(OP_PTW, 12'h0A4, 2'b00, '0, STATUS_HIT, 128'hbbbb0001, 2'b00, 16'h0);
    tbl[4]  = make_entry(OP_PTW, 12'h0A8, 2'b00, '0, STATUS_HIT, 128'hcccc0002, 2'b00, 16'h0);
    tbl[5]  = make_entry(OP_PTW, 12'h0AC, 2'b00, '0, STATUS_HIT, 128'hdddd0003, 2'b00, 16'h0);
    tbl[6]  = make_entry(OP_FILL, 12'h120, 2'b10, LINE_B, STATUS_NONE, '0, 2'b00, 16'h0);
    tbl[7]  = make_entry(OP_SNOOP_RD, 12'h0A0, 2'b00, '0, STATUS_HIT, LINE_A, 2'b01, 16'hffff);
    tbl[8]  = make_entry(OP_SNOOP_RD, 12'h120, 2'b00, '0, STATUS_HIT, LINE_B, 2'b10, 16'hffff);
    tbl[9]  = make_entry(OP_SNOOP_RD, 12'h2C0, 2'b00, '0, STATUS_MISS, '0, 2'b00, 16'h0);
    tbl[10] = make_entry(OP_PTW_SNOOP, 12'h0A0, 2'b00, '0, STATUS_HIT, LINE_A, 2'b01, 16'hffff);
    tbl[11] = make_entry(OP_SNOOP_INV, 12'h0A0, 2'b01, '0, STATUS_NONE, '0, 2'b00, 16'h0);
    tbl[12] = make_entry(OP_PTW, 12'h0A8, 2'b00, '0, STATUS_MISS, '0, 2'b00, 16'h0);
    tbl[13] = make_entry(OP_SNOOP_RD, 12'h0A0, 2'b00, '0, STATUS_MISS, '0, 2'b00, 16'h0);
    tbl[14] = make_entry(OP_PTW, 12'h124, 2'b00, '0, STATUS_HIT, 128'h2222b001, 2'b00, 16'h0);
    tbl[15] = make_entry(OP_SNOOP_RD, 12'h120, 2'b00, '0, STATUS_HIT, LINE_B, 2'b10, 16'hffff);
    tbl[16] = make_entry(OP_FILL_SNOOP, 12'h350, 2'b01, LINE_D, STATUS_MISS, '0, 2'b00, 16'h0);
    tbl[17] = make_entry(OP_PTW, 12'h35C, 2'b00, '0, STATUS_HIT, 128'h9999d003, 2'b00, 16'h0);
    tbl[18] = make_entry(OP_SNOOP_RD, 12'h350, 2'b00, '0, STATUS_HIT, LINE_D, 2'b01, 16'hffff);

    repeat (3) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);

    // State straight out of reset
    check_value(LINE_W'(o_ptw_resp_valid), '0, "ptw response valid after reset");
    check_value(LINE_W'(o_snoop_resp_valid), '0, "snoop response valid after reset");
    check_value(LINE_W'(o_fill_ready), LINE_W'(1'b1), "fill ready after reset");
    if (err_count == 0) begin
      pass_count++;
      $display("Test reset: ok");
    end else begin
      $display("Test reset: failed");
    end

    for (int i = 0; i < N_TESTS; i++) begin
      errs_before = err_count;
      if (tbl[i].op == OP_FILL) begin
        load_line(tbl[i].addr, tbl[i].way, tbl[i].data);
      end else begin
        apply_entry(tbl[i]);
      end
      if (err_count == errs_before) begin
        pass_count++;
        $display("Test %0d %s: ok", i, tbl[i].op.name());
      end else begin
        $display("Test %0d %s: failed", i, tbl[i].op.name());
      end
    end

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
             N_TESTS + 1, pass_count, N_TESTS + 1 - pass_count, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+tb
verilog/l1d_access_pkg.sv
verilog/l1d_rd_if.sv
verilog/l1d_wr_if.sv
verilog/l1d_tag_data_array.sv
verilog/l1d_dcache.sv
verilog/l1d_ptw_access.sv
verilog/l1d_snoop_port.sv
verilog/l1d_access_top.sv
tb/l1d_access_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = l1d_access_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
